/* age_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module age_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  sched_pkg::tag_t     push_tag,
    input  logic                pop,
    input  sched_pkg::slot_oh_t modify,
    input  sched_pkg::ages_t    new_ages,
    output logic                full,
    output logic                empty,
    output sched_pkg::slot_oh_t occupied,
    output sched_pkg::ages_t    old_ages,
    output sched_pkg::tag_t     head_tag,
    output sched_pkg::age_t     head_age
);
    import sched_pkg::*;

    slot_oh_t          wr_ptr;
    slot_oh_t          rd_ptr;
    slot_oh_t          wr_next;
    slot_oh_t          rd_next;
    logic [SLOT_W-1:0] wr_idx;
    logic              do_push;
    logic              do_pop;

    tag_t tags [QUEUE_DEPTH];
    age_t ages [QUEUE_DEPTH];

    // One-hot pointer to slot number.
    function automatic logic [SLOT_W-1:0] oh_to_idx(input slot_oh_t oh);
        logic [SLOT_W-1:0] idx;
        idx = '0;
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            if (oh[k]) begin
                idx = SLOT_W'(k);
            end
        end
        return idx;
    endfunction

    assign wr_next = {wr_ptr[QUEUE_DEPTH-2:0], wr_ptr[QUEUE_DEPTH-1]};
    assign rd_next = {rd_ptr[QUEUE_DEPTH-2:0], rd_ptr[QUEUE_DEPTH-1]};

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_next == rd_ptr);   // Write pointer would catch up.
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign wr_idx  = oh_to_idx(wr_ptr);

    // ********************
    // Pointers and occupancy
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= slot_oh_t'(1);
            rd_ptr   <= slot_oh_t'(1);
            occupied <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_next;
            end
            if (do_pop) begin
                rd_ptr <= rd_next;
            end
            occupied <= (occupied | (do_push ? wr_ptr : '0)) & ~(do_pop ? rd_ptr : '0);
        end
    end

    // ********************
    // Entry storage
    // ********************
    always_ff @(posedge clk) begin
        if (do_push) begin
            tags[wr_idx] <= push_tag;
        end
    end

    // A new entry starts at age 0, ahead of any age update.
    always_ff @(posedge clk) begin
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            if (do_push && wr_idx == SLOT_W'(k)) begin
                ages[k] <= '0;
            end else if (modify[k]) begin
                ages[k] <= new_ages[k*AGE_W +: AGE_W];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            old_ages[k*AGE_W +: AGE_W] = ages[k];
        end
    end

    // Head entry through the one-hot read pointer.
    always_comb begin
        head_tag = '0;
        head_age = '0;
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            if (rd_ptr[k]) begin
                head_tag = tags[k];
                head_age = ages[k];
            end
        end
    end

    a_ptr_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(wr_ptr) && $onehot(rd_ptr))
        else $error("queue pointer not one-hot");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        !(pop && empty))
        else $error("pop while empty");

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        !(push && full))
        else $error("push while full");

endmodule

`default_nettype wire

/* entry_ager.sv */
`timescale 1ns/1ps
`default_nettype none

module entry_ager (
    input  logic                age_tick,
    input  sched_pkg::slot_oh_t occupied,
    input  sched_pkg::ages_t    old_ages,
    output sched_pkg::slot_oh_t modify,
    output sched_pkg::ages_t    new_ages
);
    import sched_pkg::*;

    // ********************
    // Saturating age step
    // ********************
    always_comb begin
        age_t cur;
        logic below_max;

        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            cur       = old_ages[k*AGE_W +: AGE_W];
            below_max = (cur < age_t'(AGE_MAX));

            // Free slots and saturated ages are left alone.
            modify[k] = age_tick && occupied[k] && below_max;

            new_ages[k*AGE_W +: AGE_W] = cur + age_t'(1);
        end
    end

endmodule

`default_nettype wire

/* head_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module head_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [sched_pkg::LANES-1:0]       lane_empty,
    input  logic [sched_pkg::LANES*sched_pkg::TAG_W-1:0] head_tag,
    input  logic [sched_pkg::LANES*sched_pkg::AGE_W-1:0] head_age,
    input  logic                              pop_req,
    output logic [sched_pkg::LANES-1:0]       pop,
    output logic                              sel_valid,
    output sched_pkg::lane_t                  sel_lane,
    output sched_pkg::tag_t                   sel_tag,
    output sched_pkg::age_t                   sel_age,
    output logic                              age_tick
);
    import sched_pkg::*;

    logic [TICK_W-1:0] tick_cnt;

    // ********************
    // Oldest head select
    // ********************
    always_comb begin
        age_t cand_age;

        sel_valid = 1'b0;
        sel_lane  = '0;
        sel_tag   = '0;
        sel_age   = '0;
        for (int i = 0; i < LANES; i++) begin
            cand_age = head_age[i*AGE_W +: AGE_W];
            // Strictly greater, so the lowest lane keeps a tie.
            if (!lane_empty[i] && (!sel_valid || cand_age > sel_age)) begin
                sel_valid = 1'b1;
                sel_lane  = lane_t'(i);
                sel_tag   = head_tag[i*TAG_W +: TAG_W];
                sel_age   = cand_age;
            end
        end
    end

    always_comb begin
        pop = '0;
        if (pop_req && sel_valid) begin
            pop[sel_lane] = 1'b1;
        end
    end

    // ********************
    // Age tick
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            tick_cnt <= '0;
            age_tick <= 1'b0;
        end else begin
            if (tick_cnt == TICK_W'(AGE_PERIOD - 1)) begin
                tick_cnt <= '0;
                age_tick <= 1'b1;   // One cycle in every AGE_PERIOD.
            end else begin
                tick_cnt <= tick_cnt + TICK_W'(1);
                age_tick <= 1'b0;
            end
        end
    end

    a_pop_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(pop))
        else $error("more than one lane popped");

endmodule

`default_nettype wire

/* list.f */
sched_pkg.sv
wb_cmd_port.sv
age_queue.sv
entry_ager.sv
head_arbiter.sv
sched_top.sv
tb_clock.sv
sched_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the scheduler testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module sched_tb \
    -f list.f -o sched_sim > build.log 2>&1 \
    && ./obj_dir/sched_sim | tee sim.log \
    || echo "build or simulation error, see build.log"

grep -q "Verification passed" sim.log 2>/dev/null && exit 0 || exit 1

/* sched_pkg.sv */
`default_nettype none

package sched_pkg;

    // ********************
    // Sizes and timing
    // ********************
    localparam int LANES       = 4;
    localparam int QUEUE_DEPTH = 8;    // One slot stays free, so 7 usable.
    localparam int TAG_W       = 8;
    localparam int AGE_W       = 8;
    localparam int AGE_PERIOD  = 4;    // Cycles between age ticks.
    localparam int AGE_MAX     = 255;
    localparam int LANE_W      = 2;
    localparam int SLOT_W      = 3;    // Index of a slot inside a lane.
    localparam int TICK_W      = 2;    // Width of the tick counter.

    // Wishbone read word layout.
    localparam int WB_W      = 32;
    localparam int VALID_BIT = 31;
    localparam int LANE_LSB  = 16;
    localparam int AGE_LSB   = 8;
    localparam int TAG_LSB   = 0;

    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [AGE_W-1:0]             age_t;
    typedef logic [LANE_W-1:0]            lane_t;
    typedef logic [QUEUE_DEPTH-1:0]       slot_oh_t;
    typedef logic [QUEUE_DEPTH*AGE_W-1:0] ages_t;

    typedef enum logic {
        head_idle,
        head_ack
    } head_state_t;

endpackage

`default_nettype wire

/* sched_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sched_tb;
    import sched_pkg::*;

    logic            clk;
    logic            rst;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    lane_t           wb_adr;
    logic [WB_W-1:0] wb_dat_w;
    logic [WB_W-1:0] wb_dat_r;
    logic            wb_ack;

    tag_t  sb [LANES][$];   // Expected tags per lane, oldest first.
    logic  rd_pend;         // A read is waiting for its ack.
    logic  wr_blocked;      // Window in which a write must not be acked.
    logic  exp_valid;
    lane_t exp_lane;
    tag_t  exp_tag;
    age_t  exp_age;
    logic  chk_age;
    int    cyc_n;           // Edges since reset, same count as the DUT tick counter.
    int    last_push;
    int    err_cnt;
    int    test_cnt;
    int    fail_cnt;
    int    test_err;
    int    seed;

    tb_clock u_clk (
        .clk (clk),
        .rst (rst)
    );

    sched_top dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_n <= 0;
        end else begin
            cyc_n <= cyc_n + 1;
        end
    end

    // ********************
    // Read word checks
    // ********************
    a_valid: assert property (@(posedge clk) disable iff (rst)
        (wb_ack && rd_pend) |-> (wb_dat_r[VALID_BIT] == exp_valid))
        else begin
            $display("ERROR %0t wb_dat_r.valid expected %0b actual %0b", $time,
                $sampled(exp_valid), $sampled(wb_dat_r[VALID_BIT]));
            err_cnt++;
        end

    a_lane: assert property (@(posedge clk) disable iff (rst)
        (wb_ack && rd_pend && exp_valid) |-> (wb_dat_r[LANE_LSB +: LANE_W] == exp_lane))
        else begin
            $display("ERROR %0t wb_dat_r.lane expected %0d actual %0d", $time,
                $sampled(exp_lane), $sampled(wb_dat_r[LANE_LSB +: LANE_W]));
            err_cnt++;
        end

    a_tag: assert property (@(posedge clk) disable iff (rst)
        (wb_ack && rd_pend && exp_valid) |-> (wb_dat_r[TAG_LSB +: TAG_W] == exp_tag))
        else begin
            $display("ERROR %0t wb_dat_r.tag expected %0h actual %0h", $time,
                $sampled(exp_tag), $sampled(wb_dat_r[TAG_LSB +: TAG_W]));
            err_cnt++;
        end

    a_age: assert property (@(posedge clk) disable iff (rst)
        (wb_ack && rd_pend && chk_age) |-> (wb_dat_r[AGE_LSB +: AGE_W] == exp_age))
        else begin
            $display("ERROR %0t wb_dat_r.age expected %0d actual %0d", $time,
                $sampled(exp_age), $sampled(wb_dat_r[AGE_LSB +: AGE_W]));
            err_cnt++;
        end

    a_pad: assert property (@(posedge clk) disable iff (rst)
        (wb_ack && rd_pend) |-> (wb_dat_r[VALID_BIT-1:LANE_LSB+LANE_W] == '0))
        else begin
            $display("ERROR %0t wb_dat_r.unused expected 0 actual %0h", $time,
                $sampled(wb_dat_r[VALID_BIT-1:LANE_LSB+LANE_W]));
            err_cnt++;
        end

    a_empty: assert property (@(posedge clk) disable iff (rst)
        (wb_ack && rd_pend && !exp_valid) |-> (wb_dat_r == '0))
        else begin
            $display("ERROR %0t wb_dat_r expected 0 actual %h", $time, $sampled(wb_dat_r));
            err_cnt++;
        end

    a_blocked: assert property (@(posedge clk) disable iff (rst)
        wr_blocked |-> !wb_ack)
        else begin
            $display("ERROR %0t wb_ack expected 0 actual 1", $time);
            err_cnt++;
        end

    // ********************
    // Bus tasks
    // ********************
    task automatic write_tag(input lane_t lane, input tag_t tag, input int limit);
        int n;
        n = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= lane;
        wb_dat_w <= WB_W'(tag);
        do begin
            @(posedge clk);
            n++;
        end while (!(wb_ack && !rd_pend) && n < limit);   // A read ack is not ours.
        if (wb_ack && !rd_pend) begin
            last_push = cyc_n;   // Edge at which the entry was written.
            sb[lane].push_back(tag);
        end else begin
            $display("Timeout: write to lane %0d got no ack in %0d cycles", lane, limit);
            err_cnt++;
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic expect_head(input int lane, input logic age_on, input age_t age);
        if (lane < 0) begin
            exp_valid = 1'b0;
            exp_lane  = '0;
            exp_tag   = '0;
        end else begin
            exp_valid = 1'b1;
            exp_lane  = lane_t'(lane);
            exp_tag   = sb[lane].pop_front();
        end
        chk_age = age_on;
        exp_age = age;
    endtask

    // Lane -1 means every lane should be empty.
    task automatic read_head(input int lane, input logic age_on, input age_t age);
        int n;
        n = 0;
        @(posedge clk);
        expect_head(lane, age_on, age);
        rd_pend <= 1'b1;
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        wb_we   <= 1'b0;
        wb_adr  <= '0;
        do begin
            @(posedge clk);
            n++;
        end while (!wb_ack && n < 10);
        if (!wb_ack) begin
            $display("Timeout: read got no ack in 10 cycles");
            err_cnt++;
        end
        rd_pend <= 1'b0;
        wb_cyc  <= 1'b0;
        wb_stb  <= 1'b0;
    endtask

    // Turns a stalled write into a read for one request, then restores it.
    task automatic read_during_write(input int lane);
        int n;
        n = 0;
        expect_head(lane, 1'b0, '0);
        rd_pend <= 1'b1;
        wb_we   <= 1'b0;
        do begin
            @(posedge clk);
            n++;
        end while (!wb_ack && n < 10);
        if (!wb_ack) begin
            $display("Timeout: read beside a stalled write got no ack in 10 cycles");
            err_cnt++;
        end
        rd_pend <= 1'b0;
        wb_we   <= 1'b1;
    endtask

    task automatic wait_cycles(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        repeat (2) @(posedge clk);   // Lets the last assertion report first.
        test_cnt++;
        if (err_cnt == test_err) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err);
        end
        test_err = err_cnt;
    endtask

    // ********************
    // Stimulus
    // ********************
    initial begin
        tag_t t;
        int   p1;

        seed       = 12;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        rd_pend    = 1'b0;
        wr_blocked = 1'b0;
        exp_valid  = 1'b0;
        exp_lane   = '0;
        exp_tag    = '0;
        exp_age    = '0;
        chk_age    = 1'b0;
        last_push  = 0;
        err_cnt    = 0;
        test_cnt   = 0;
        fail_cnt   = 0;
        test_err   = 0;
        for (int i = 0; i < 10 && rst; i++) begin
            @(posedge clk);
        end

        for (int i = 0; i < 3; i++) begin
            t = tag_t'($random(seed));
            write_tag(1, t, 10);
        end
        for (int i = 0; i < 3; i++) begin
            read_head(1, 1'b0, '0);
        end
        finish_test("fifo order");

        write_tag(3, tag_t'($random(seed)), 10);
        wait_cycles(2 * AGE_PERIOD);
        write_tag(0, tag_t'($random(seed)), 10);
        read_head(3, 1'b0, '0);
        read_head(0, 1'b0, '0);
        finish_test("oldest first");

        // First push lands on a tick edge, the second three edges later.
        for (int i = 0; i < 2 * AGE_PERIOD && (cyc_n % AGE_PERIOD) != 2; i++) begin
            @(posedge clk);
        end
        write_tag(2, tag_t'($random(seed)), 10);
        p1 = last_push;
        write_tag(1, tag_t'($random(seed)), 10);
        assert ((p1 - 1) / AGE_PERIOD == (last_push - 1) / AGE_PERIOD)
        else begin
            $display("Tie pushes fell into different age tick windows");
            err_cnt++;
        end
        read_head(1, 1'b0, '0);
        read_head(2, 1'b0, '0);
        finish_test("tie rule");

        read_head(-1, 1'b0, '0);
        write_tag(1, tag_t'($random(seed)), 10);
        read_head(1, 1'b0, '0);
        finish_test("empty read");

        for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
            write_tag(2, tag_t'($random(seed)), 10);
        end
        t = tag_t'($random(seed));
        fork
            write_tag(2, t, 40);
            begin
                @(posedge clk);
                wr_blocked <= 1'b1;
                repeat (20) @(posedge clk);
                wr_blocked <= 1'b0;
                read_during_write(2);
            end
        join
        for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
            read_head(2, 1'b0, '0);
        end
        finish_test("full lane");

        write_tag(0, tag_t'($random(seed)), 10);
        wait_cycles((AGE_MAX + 5) * AGE_PERIOD);
        read_head(0, 1'b1, age_t'(AGE_MAX));
        finish_test("age saturation");

        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sched_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  sched_pkg::lane_t           wb_adr,
    input  logic [sched_pkg::WB_W-1:0] wb_dat_w,
    output logic [sched_pkg::WB_W-1:0] wb_dat_r,
    output logic                       wb_ack
);
    import sched_pkg::*;

    logic [LANES-1:0]       push;
    logic [LANES-1:0]       pop;
    logic [LANES-1:0]       lane_full;
    logic [LANES-1:0]       lane_empty;
    logic [LANES*TAG_W-1:0] head_tag;
    logic [LANES*AGE_W-1:0] head_age;
    tag_t                   push_tag;
    logic                   pop_req;
    logic                   sel_valid;
    lane_t                  sel_lane;
    tag_t                   sel_tag;
    age_t                   sel_age;
    logic                   age_tick;

    wb_cmd_port u_port (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .lane_full (lane_full),
        .sel_valid (sel_valid),
        .sel_lane  (sel_lane),
        .sel_tag   (sel_tag),
        .sel_age   (sel_age),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .push      (push),
        .push_tag  (push_tag),
        .pop_req   (pop_req)
    );

    // ********************
    // Lanes
    // ********************
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        slot_oh_t occupied;
        slot_oh_t modify;
        ages_t    old_ages;
        ages_t    new_ages;

        age_queue u_queue (
            .clk      (clk),
            .rst      (rst),
            .push     (push[g]),
            .push_tag (push_tag),
            .pop      (pop[g]),
            .modify   (modify),
            .new_ages (new_ages),
            .full     (lane_full[g]),
            .empty    (lane_empty[g]),
            .occupied (occupied),
            .old_ages (old_ages),
            .head_tag (head_tag[g*TAG_W +: TAG_W]),
            .head_age (head_age[g*AGE_W +: AGE_W])
        );

        entry_ager u_ager (
            .age_tick (age_tick),
            .occupied (occupied),
            .old_ages (old_ages),
            .modify   (modify),
            .new_ages (new_ages)
        );
    end

    head_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .lane_empty (lane_empty),
        .head_tag   (head_tag),
        .head_age   (head_age),
        .pop_req    (pop_req),
        .pop        (pop),
        .sel_valid  (sel_valid),
        .sel_lane   (sel_lane),
        .sel_tag    (sel_tag),
        .sel_age    (sel_age),
        .age_tick   (age_tick)
    );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period.
    end

    // Reset held over two rising edges.
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* wb_cmd_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_cmd_port (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  sched_pkg::lane_t            wb_adr,
    input  logic [sched_pkg::WB_W-1:0]  wb_dat_w,
    input  logic [sched_pkg::LANES-1:0] lane_full,
    input  logic                        sel_valid,
    input  sched_pkg::lane_t            sel_lane,
    input  sched_pkg::tag_t             sel_tag,
    input  sched_pkg::age_t             sel_age,
    output logic                        wb_ack,
    output logic [sched_pkg::WB_W-1:0]  wb_dat_r,
    output logic [sched_pkg::LANES-1:0] push,
    output sched_pkg::tag_t             push_tag,
    output logic                        pop_req
);
    import sched_pkg::*;

    head_state_t     state;
    logic            req;
    logic            wr_ok;
    logic [WB_W-1:0] rd_word;

    // Only one request is taken per bus cycle. The ack state blocks the repeat.
    assign req   = wb_cyc && wb_stb && (state == head_idle);
    assign wr_ok = req && wb_we && !lane_full[wb_adr];   // Stalls while the lane is full.

    always_comb begin
        push         = '0;
        push[wb_adr] = wr_ok;
    end

    assign push_tag = wb_dat_w[TAG_LSB +: TAG_W];
    assign pop_req  = req && !wb_we;

    // Read word. All zero when no lane has an entry.
    always_comb begin
        rd_word = '0;
        if (sel_valid) begin
            rd_word[VALID_BIT]           = 1'b1;
            rd_word[LANE_LSB +: LANE_W]  = sel_lane;
            rd_word[AGE_LSB +: AGE_W]    = sel_age;
            rd_word[TAG_LSB +: TAG_W]    = sel_tag;
        end
    end

    // ********************
    // Ack state machine
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= head_idle;
        end else begin
            case (state)
                head_idle: begin
                    if (wr_ok || pop_req) begin
                        state <= head_ack;
                    end
                end
                default: state <= head_idle;   // Master drops stb after the ack.
            endcase
        end
    end

    assign wb_ack = (state == head_ack);

    always_ff @(posedge clk) begin
        if (pop_req) begin
            wb_dat_r <= rd_word;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for two cycles");

endmodule

`default_nettype wire
